// ==== filelist.f ====
bus_pkg.sv
cmd_wb_master.sv
wb_intercon.sv
wb_dev_bridge.sv
bus_top.sv
tb_bus_assert.sv
tb_bus_checker.sv
tb_bus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_bus -o tb_bus_sim

sim_out=$(./obj_dir/tb_bus_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

// ==== tb_bus.sv ====
// Testbench top for the peripheral bus with clock, reset, device models, test table and watchdog.
`default_nettype none

module tb_bus
    import bus_pkg::*;
();

    localparam int unsigned NUM_DEV     = 4;
    localparam int unsigned TIMEOUT_CYC = 32;
    localparam int unsigned N_TESTS     = 15;
    localparam int unsigned WDOG_CYC    = N_TESTS * (TIMEOUT_CYC + 40);
    localparam logic [31:0] SEED        = 32'h0cd1_462b;

    logic                               clk = 1'b0;
    logic                               rst_n;
    logic                               cmd_valid;
    logic                               cmd_we;
    logic [ADDR_W-1:0]                  cmd_addr;
    logic [DATA_W-1:0]                  cmd_wdata;
    logic [BE_W-1:0]                    cmd_be;
    logic                               cmd_busy;
    logic                               cmd_done;
    logic                               cmd_err;
    logic [DATA_W-1:0]                  cmd_rdata;

    logic [NUM_DEV-1:0]                 dev_busy;
    logic [NUM_DEV-1:0][DATA_W-1:0]     dev_rdata;
    logic [NUM_DEV-1:0]                 dev_rdata_valid;
    logic [NUM_DEV-1:0][LOC_W-1:0]      dev_addr;
    logic [NUM_DEV-1:0][DATA_W-1:0]     dev_wdata;
    logic [NUM_DEV-1:0][BE_W-1:0]       dev_be;
    logic [NUM_DEV-1:0]                 dev_we;
    logic [NUM_DEV-1:0]                 dev_re;

    // ##############################
    // Test table.
    // ##############################

    logic [8*12-1:0]    t_name  [N_TESTS];
    logic               t_we    [N_TESTS];
    logic [ADDR_W-1:0]  t_addr  [N_TESTS];
    logic [DATA_W-1:0]  t_wdata [N_TESTS];
    logic [BE_W-1:0]    t_be    [N_TESTS];
    logic [DATA_W-1:0]  t_rdata [N_TESTS];
    logic               t_err   [N_TESTS];
    int unsigned        n_ent = 0;
    logic [DATA_W-1:0]  ref_mem [NUM_DEV][16];

    logic [8*12-1:0]    cur_name;
    logic [DATA_W-1:0]  cur_rdata;
    logic               cur_err;
    int unsigned        tests;
    int unsigned        failed;

    // Peripheral model state.
    logic [DATA_W-1:0]  dev_mem [NUM_DEV][16];
    int unsigned        rd_cnt  [NUM_DEV];
    logic [3:0]         rd_word [NUM_DEV];
    logic [31:0]        rng;

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Power-on contents differ for every device and word.
    function automatic logic [31:0] fill_word(input int unsigned dev, input int unsigned word);
        return 32'hc0de_0000 ^ (dev << 12) ^ (word * 32'h0001_0101);
    endfunction

    task automatic add_entry(input logic [8*12-1:0] name, input logic we,
                             input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] be, input logic err);
        int unsigned dev;
        int unsigned word;
        dev             = addr[DEV_SEL_LSB +: 2];
        word            = addr[5:2];
        t_name[n_ent]   = name;
        t_we[n_ent]     = we;
        t_addr[n_ent]   = addr;
        t_wdata[n_ent]  = wdata;
        t_be[n_ent]     = be;
        t_err[n_ent]    = err;
        t_rdata[n_ent]  = '0;
        if (!err && we) begin
            for (int b = 0; b < BE_W; b++) begin
                if (be[b]) begin
                    ref_mem[dev][word][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end else if (!err) begin
            t_rdata[n_ent] = ref_mem[dev][word];
        end
        n_ent++;
    endtask

    task automatic build_table();
        for (int k = 0; k < NUM_DEV; k++) begin
            for (int w = 0; w < 16; w++) begin
                ref_mem[k][w] = fill_word(k, w);
            end
        end
        add_entry("wr_dev0",      1'b1, 32'h0000_0010, 32'h1111_2222, 4'hf, 1'b0);
        add_entry("wr_dev1",      1'b1, 32'h0000_1024, 32'h3333_4444, 4'h3, 1'b0);
        add_entry("wr_dev2",      1'b1, 32'h0000_2008, 32'hdead_beef, 4'hc, 1'b0);
        add_entry("wr_dev3",      1'b1, 32'h0000_303c, 32'h5566_7788, 4'hf, 1'b0);
        add_entry("rd_dev0",      1'b0, 32'h0000_0010, 32'h0,         4'hf, 1'b0);
        add_entry("rd_dev1",      1'b0, 32'h0000_1024, 32'h0,         4'hf, 1'b0);
        add_entry("rd_dev2",      1'b0, 32'h0000_2008, 32'h0,         4'hf, 1'b0);
        add_entry("rd_dev3",      1'b0, 32'h0000_303c, 32'h0,         4'hf, 1'b0);
        add_entry("wr_dev2_mix",  1'b1, 32'h0000_2008, 32'h0102_0304, 4'h5, 1'b0);
        add_entry("rd_dev2_mix",  1'b0, 32'h0000_2008, 32'h0,         4'hf, 1'b0);
        add_entry("rd_dev1_init", 1'b0, 32'h0000_1000, 32'h0,         4'hf, 1'b0);
        add_entry("wr_unmapped",  1'b1, 32'h0000_4000, 32'hffff_ffff, 4'hf, 1'b1);
        add_entry("rd_unmapped",  1'b0, 32'h8000_0010, 32'h0,         4'hf, 1'b1);
        add_entry("rd_dev3_tmo",  1'b0, 32'h0000_3ffc, 32'h0,         4'hf, 1'b1);
        add_entry("rd_dev0_post", 1'b0, 32'h0000_0010, 32'h0,         4'hf, 1'b0);
    endtask

    // ##############################
    // DUT and checker.
    // ##############################

    bus_top #(
        .NUM_DEV     (NUM_DEV),
        .TIMEOUT_CYC (TIMEOUT_CYC)
    ) u_dut (
        .clk_i             (clk),
        .rst_n_i           (rst_n),
        .cmd_valid_i       (cmd_valid),
        .cmd_we_i          (cmd_we),
        .cmd_addr_i        (cmd_addr),
        .cmd_wdata_i       (cmd_wdata),
        .cmd_be_i          (cmd_be),
        .cmd_busy_o        (cmd_busy),
        .cmd_done_o        (cmd_done),
        .cmd_err_o         (cmd_err),
        .cmd_rdata_o       (cmd_rdata),
        .dev_busy_i        (dev_busy),
        .dev_rdata_i       (dev_rdata),
        .dev_rdata_valid_i (dev_rdata_valid),
        .dev_addr_o        (dev_addr),
        .dev_wdata_o       (dev_wdata),
        .dev_be_o          (dev_be),
        .dev_we_o          (dev_we),
        .dev_re_o          (dev_re)
    );

    tb_bus_checker #(
        .NUM_DEV     (NUM_DEV),
        .TIMEOUT_CYC (TIMEOUT_CYC)
    ) u_chk (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .name_i      (cur_name),
        .exp_we_i    (cmd_we),
        .exp_addr_i  (cmd_addr),
        .exp_wdata_i (cmd_wdata),
        .exp_be_i    (cmd_be),
        .exp_rdata_i (cur_rdata),
        .exp_err_i   (cur_err),
        .cmd_valid_i (cmd_valid),
        .cmd_busy_i  (cmd_busy),
        .cmd_done_i  (cmd_done),
        .cmd_err_i   (cmd_err),
        .cmd_rdata_i (cmd_rdata),
        .dev_addr_i  (dev_addr),
        .dev_wdata_i (dev_wdata),
        .dev_be_i    (dev_be),
        .dev_we_i    (dev_we),
        .dev_re_i    (dev_re),
        .tests_o     (tests),
        .failed_o    (failed)
    );

    // ##############################
    // Peripheral models.
    // ##############################

    // Random busy and 1 to 3 cycle read latency. Device 3 never answers at 0xffc.
    initial begin
        rng             = SEED;
        dev_busy        = '0;
        dev_rdata       = '0;
        dev_rdata_valid = '0;
        for (int k = 0; k < NUM_DEV; k++) begin
            rd_cnt[k]  = 0;
            rd_word[k] = '0;
            for (int w = 0; w < 16; w++) begin
                dev_mem[k][w] = fill_word(k, w);
            end
        end
        forever begin
            @(posedge clk);
            #2;
            for (int k = 0; k < NUM_DEV; k++) begin
                dev_rdata_valid[k] = 1'b0;
                if (rd_cnt[k] != 0) begin
                    rd_cnt[k]--;
                    if (rd_cnt[k] == 0) begin
                        dev_rdata_valid[k] = 1'b1;
                        dev_rdata[k]       = dev_mem[k][rd_word[k]];
                    end
                end
                if (dev_we[k]) begin
                    for (int b = 0; b < BE_W; b++) begin
                        if (dev_be[k][b]) begin
                            dev_mem[k][dev_addr[k][5:2]][8*b +: 8] = dev_wdata[k][8*b +: 8];
                        end
                    end
                end
                if (dev_re[k] && !(k == 3 && dev_addr[k] == 12'hffc)) begin
                    rng        = xorshift32(rng);
                    rd_cnt[k]  = 1 + int'(rng[7:0] % 8'd3);
                    rd_word[k] = dev_addr[k][5:2];
                end
                rng         = xorshift32(rng);
                dev_busy[k] = (rng[1:0] == 2'b00);
            end
        end
    end

    // ##############################
    // Stimulus and watchdog.
    // ##############################

    initial begin
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_we    = 1'b0;
        cmd_addr  = '0;
        cmd_wdata = '0;
        cmd_be    = '0;
        cur_name  = '0;
        cur_rdata = '0;
        cur_err   = 1'b0;
        build_table();
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        for (int i = 0; i < N_TESTS; i++) begin
            cur_name  = t_name[i];
            cur_rdata = t_rdata[i];
            cur_err   = t_err[i];
            cmd_we    = t_we[i];
            cmd_addr  = t_addr[i];
            cmd_wdata = t_wdata[i];
            cmd_be    = t_be[i];
            cmd_valid = 1'b1;
            @(posedge clk);
            #2;
            cmd_valid = 1'b0;
            while (!cmd_done) begin
                @(posedge clk);
                #2;
            end
            @(posedge clk);
            #2;
        end
        repeat (2) @(posedge clk);
        $display("tests run: %0d, failed: %0d", tests, failed);
        if (failed == 0 && tests == N_TESTS + 1) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (WDOG_CYC) @(posedge clk);
        $display("watchdog expired, a command never completed");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_bus_checker.sv ====
// Result checker that watches the bus ports and compares each command with its table entry.
`default_nettype none

module tb_bus_checker
    import bus_pkg::*;
#(
    parameter int unsigned NUM_DEV     = 4,
    parameter int unsigned TIMEOUT_CYC = 32
) (
    input  wire                             clk_i,
    input  wire                             rst_n_i,
    input  wire  [8*12-1:0]                 name_i,
    input  wire                             exp_we_i,
    input  wire  [ADDR_W-1:0]               exp_addr_i,
    input  wire  [DATA_W-1:0]               exp_wdata_i,
    input  wire  [BE_W-1:0]                 exp_be_i,
    input  wire  [DATA_W-1:0]               exp_rdata_i,
    input  wire                             exp_err_i,
    input  wire                             cmd_valid_i,
    input  wire                             cmd_busy_i,
    input  wire                             cmd_done_i,
    input  wire                             cmd_err_i,
    input  wire  [DATA_W-1:0]               cmd_rdata_i,
    input  wire  [NUM_DEV-1:0][LOC_W-1:0]   dev_addr_i,
    input  wire  [NUM_DEV-1:0][DATA_W-1:0]  dev_wdata_i,
    input  wire  [NUM_DEV-1:0][BE_W-1:0]    dev_be_i,
    input  wire  [NUM_DEV-1:0]              dev_we_i,
    input  wire  [NUM_DEV-1:0]              dev_re_i,
    output logic [31:0]                     tests_o,
    output logic [31:0]                     failed_o
);

    localparam int unsigned IDX_W = $clog2(NUM_DEV);

    int unsigned        test_cnt  = 0;
    int unsigned        fail_cnt  = 0;
    int unsigned        pulses    = 0;
    int unsigned        wrong     = 0;
    int unsigned        lat       = 0;
    logic               idle_done = 1'b0;
    logic               bad       = 1'b0;
    logic               hit;
    logic [IDX_W-1:0]   dev;

    assign tests_o  = test_cnt;
    assign failed_o = fail_cnt;
    assign hit      = (exp_addr_i[ADDR_W-1:DEV_SEL_LSB+IDX_W] == '0);
    assign dev      = exp_addr_i[DEV_SEL_LSB +: IDX_W];

    task automatic value_err(input string field, input logic [31:0] exp, input logic [31:0] act);
        $display("ERR %s %s: expected %h, actual %h", name_i, field, exp, act);
        bad = 1'b1;
    endtask

    task automatic finish_test();
        test_cnt++;
        if (cmd_err_i !== exp_err_i) begin
            value_err("err", 32'(exp_err_i), 32'(cmd_err_i));
        end
        if ((!exp_we_i || exp_err_i) && cmd_rdata_i !== exp_rdata_i) begin
            value_err("rdata", exp_rdata_i, cmd_rdata_i);
        end
        if (hit && pulses != 1) begin
            $display("%s: expected one pulse on device %0d, saw %0d", name_i, dev, pulses);
            bad = 1'b1;
        end
        if (!hit && pulses != 0) begin
            $display("%s: unmapped address still reached a device", name_i);
            bad = 1'b1;
        end
        if (wrong != 0) begin
            $display("%s: pulse on the wrong device or of the wrong kind", name_i);
            bad = 1'b1;
        end
        if (lat > TIMEOUT_CYC + 4) begin
            $display("%s: completion took %0d cycles, beyond the timeout bound", name_i, lat);
            bad = 1'b1;
        end
        if (bad) begin
            fail_cnt++;
        end else begin
            $display("ok   %s", name_i);
        end
    endtask

    // Mid-cycle sampling, so every DUT output has settled.
    always @(negedge clk_i) begin
        if (rst_n_i && !idle_done) begin
            idle_done = 1'b1;
            test_cnt++;
            if (cmd_busy_i || cmd_done_i || (|dev_we_i) || (|dev_re_i)) begin
                $display("reset_idle: busy, done or a device pulse is high after reset");
                fail_cnt++;
            end else begin
                $display("ok   reset_idle");
            end
        end
        if (cmd_valid_i && !cmd_busy_i) begin
            pulses = 0;
            wrong  = 0;
            lat    = 0;
            bad    = 1'b0;
        end else if (cmd_busy_i) begin
            lat++;
        end
        for (int k = 0; k < NUM_DEV; k++) begin
            if (dev_we_i[k] || dev_re_i[k]) begin
                pulses++;
                if (!hit || IDX_W'(k) != dev || dev_we_i[k] != exp_we_i) begin
                    wrong++;
                end else begin
                    if (dev_addr_i[k] != exp_addr_i[LOC_W-1:0]) begin
                        value_err("dev_addr", 32'(exp_addr_i[LOC_W-1:0]), 32'(dev_addr_i[k]));
                    end
                    if (dev_we_i[k] && dev_wdata_i[k] != exp_wdata_i) begin
                        value_err("dev_wdata", exp_wdata_i, dev_wdata_i[k]);
                    end
                    if (dev_we_i[k] && dev_be_i[k] != exp_be_i) begin
                        value_err("dev_be", 32'(exp_be_i), 32'(dev_be_i[k]));
                    end
                end
            end
        end
        if (cmd_done_i) begin
            finish_test();
        end
    end

endmodule

`default_nettype wire

// ==== tb_bus_assert.sv ====
// Wishbone protocol and device pulse assertions bound into the bus top level.
`default_nettype none

module tb_bus_assert #(
    parameter int unsigned NUM_DEV = 4
) (
    input  wire                 clk_i,
    input  wire                 rst_n_i,
    input  wire                 wb_cyc_i,
    input  wire                 wb_stb_i,
    input  wire  [NUM_DEV-1:0]  slv_ack_i,
    input  wire  [NUM_DEV-1:0]  slv_stb_i,
    input  wire  [NUM_DEV-1:0]  dev_we_i,
    input  wire  [NUM_DEV-1:0]  dev_re_i
);

    a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i) wb_stb_i |-> wb_cyc_i)
        else $error("stb high outside a bus cycle");

    a_we_re_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (dev_we_i & dev_re_i) == '0)
        else $error("write and read pulse high together on one device");

    a_one_slave: assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(slv_stb_i))
        else $error("more than one slave strobe high");

    // Slave acks come straight from the bridge FSMs, ahead of the return mux.
    a_ack_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (|slv_ack_i) |-> wb_cyc_i)
        else $error("ack high outside a bus cycle");

endmodule

bind bus_top tb_bus_assert #(
    .NUM_DEV (NUM_DEV)
) u_assert (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .wb_cyc_i  (wb_cyc),
    .wb_stb_i  (wb_stb),
    .slv_ack_i (slv_ack),
    .slv_stb_i (slv_stb),
    .dev_we_i  (dev_we_o),
    .dev_re_i  (dev_re_o)
);

`default_nettype wire

// ==== bus_top.sv ====
// Peripheral bus top: command master, interconnect and one bridge per device.
`default_nettype none

module bus_top
    import bus_pkg::*;
#(
    parameter int unsigned NUM_DEV     = 4,
    parameter int unsigned TIMEOUT_CYC = 32
) (
    input  wire                             clk_i,
    input  wire                             rst_n_i,

    // Processor port.
    input  wire                             cmd_valid_i,
    input  wire                             cmd_we_i,
    input  wire  [ADDR_W-1:0]               cmd_addr_i,
    input  wire  [DATA_W-1:0]               cmd_wdata_i,
    input  wire  [BE_W-1:0]                 cmd_be_i,
    output logic                            cmd_busy_o,
    output logic                            cmd_done_o,
    output logic                            cmd_err_o,
    output logic [DATA_W-1:0]               cmd_rdata_o,

    // Peripheral ports, one slot per device.
    input  wire  [NUM_DEV-1:0]              dev_busy_i,
    input  wire  [NUM_DEV-1:0][DATA_W-1:0]  dev_rdata_i,
    input  wire  [NUM_DEV-1:0]              dev_rdata_valid_i,
    output logic [NUM_DEV-1:0][LOC_W-1:0]   dev_addr_o,
    output logic [NUM_DEV-1:0][DATA_W-1:0]  dev_wdata_o,
    output logic [NUM_DEV-1:0][BE_W-1:0]    dev_be_o,
    output logic [NUM_DEV-1:0]              dev_we_o,
    output logic [NUM_DEV-1:0]              dev_re_o
);

    // ##############################
    // Shared Wishbone wires.
    // ##############################

    logic                           wb_cyc;
    logic                           wb_stb;
    logic                           wb_we;
    logic [ADDR_W-1:0]              wb_adr;
    logic [DATA_W-1:0]              wb_dat_w;
    logic [BE_W-1:0]                wb_sel;
    logic [DATA_W-1:0]              wb_dat_r;
    logic                           wb_ack;
    logic                           wb_err;

    logic [NUM_DEV-1:0]             slv_stb;
    logic [NUM_DEV-1:0]             slv_ack;
    logic [NUM_DEV-1:0][DATA_W-1:0] slv_dat_r;

    cmd_wb_master #(
        .TIMEOUT_CYC (TIMEOUT_CYC)
    ) u_master (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_we_i    (cmd_we_i),
        .cmd_addr_i  (cmd_addr_i),
        .cmd_wdata_i (cmd_wdata_i),
        .cmd_be_i    (cmd_be_i),
        .cmd_busy_o  (cmd_busy_o),
        .cmd_done_o  (cmd_done_o),
        .cmd_err_o   (cmd_err_o),
        .cmd_rdata_o (cmd_rdata_o),
        .wb_cyc_o    (wb_cyc),
        .wb_stb_o    (wb_stb),
        .wb_we_o     (wb_we),
        .wb_adr_o    (wb_adr),
        .wb_dat_o    (wb_dat_w),
        .wb_sel_o    (wb_sel),
        .wb_dat_i    (wb_dat_r),
        .wb_ack_i    (wb_ack),
        .wb_err_i    (wb_err)
    );

    wb_intercon #(
        .NUM_DEV (NUM_DEV)
    ) u_intercon (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wb_cyc_i  (wb_cyc),
        .wb_stb_i  (wb_stb),
        .wb_adr_i  (wb_adr),
        .wb_dat_o  (wb_dat_r),
        .wb_ack_o  (wb_ack),
        .wb_err_o  (wb_err),
        .slv_stb_o (slv_stb),
        .slv_ack_i (slv_ack),
        .slv_dat_i (slv_dat_r)
    );

    for (genvar k = 0; k < NUM_DEV; k++) begin : g_dev
        wb_dev_bridge u_bridge (
            .clk_i             (clk_i),
            .rst_n_i           (rst_n_i),
            .wb_stb_i          (slv_stb[k]),
            .wb_we_i           (wb_we),
            .wb_adr_i          (wb_adr[LOC_W-1:0]),
            .wb_dat_i          (wb_dat_w),
            .wb_sel_i          (wb_sel),
            .wb_ack_o          (slv_ack[k]),
            .wb_dat_o          (slv_dat_r[k]),
            .dev_busy_i        (dev_busy_i[k]),
            .dev_rdata_i       (dev_rdata_i[k]),
            .dev_rdata_valid_i (dev_rdata_valid_i[k]),
            .dev_addr_o        (dev_addr_o[k]),
            .dev_wdata_o       (dev_wdata_o[k]),
            .dev_be_o          (dev_be_o[k]),
            .dev_we_o          (dev_we_o[k]),
            .dev_re_o          (dev_re_o[k])
        );
    end

endmodule

`default_nettype wire

// ==== wb_dev_bridge.sv ====
// Wishbone classic slave that turns bus cycles into a busy, write and read pulse handshake.
`default_nettype none

module wb_dev_bridge
    import bus_pkg::*;
(
    input  wire                 clk_i,
    input  wire                 rst_n_i,

    // Bus side, strobe already carries the device select.
    input  wire                 wb_stb_i,
    input  wire                 wb_we_i,
    input  wire  [LOC_W-1:0]    wb_adr_i,
    input  wire  [DATA_W-1:0]   wb_dat_i,
    input  wire  [BE_W-1:0]     wb_sel_i,
    output logic                wb_ack_o,
    output logic [DATA_W-1:0]   wb_dat_o,

    // Peripheral side.
    input  wire                 dev_busy_i,
    input  wire  [DATA_W-1:0]   dev_rdata_i,
    input  wire                 dev_rdata_valid_i,
    output logic [LOC_W-1:0]    dev_addr_o,
    output logic [DATA_W-1:0]   dev_wdata_o,
    output logic [BE_W-1:0]     dev_be_o,
    output logic                dev_we_o,
    output logic                dev_re_o
);

    bridge_state_e  state_q;
    logic           waiting;
    logic           issue;
    logic           take_rd;

    assign waiting = (state_q == B_IDLE) || (state_q == B_WAIT_RDY);
    assign issue   = waiting && wb_stb_i && !dev_busy_i;

    // Read data may already come back in the pulse cycle.
    assign take_rd = dev_rdata_valid_i &&
                     ((state_q == B_WAIT_RD) || ((state_q == B_ACCESS) && dev_re_o));

    // ##############################
    // Handshake FSM.
    // ##############################

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= B_IDLE;
            dev_we_o <= 1'b0;
            dev_re_o <= 1'b0;
            wb_ack_o <= 1'b0;
        end else begin
            case (state_q)
                B_IDLE, B_WAIT_RDY: begin
                    if (!wb_stb_i) begin
                        state_q <= B_IDLE;
                    end else if (dev_busy_i) begin
                        state_q <= B_WAIT_RDY;
                    end else begin
                        state_q  <= B_ACCESS;
                        dev_we_o <= wb_we_i;
                        dev_re_o <= !wb_we_i;
                    end
                end
                B_ACCESS: begin
                    dev_we_o <= 1'b0;
                    dev_re_o <= 1'b0;
                    if (dev_we_o || take_rd) begin
                        state_q  <= B_ACK;
                        wb_ack_o <= 1'b1;
                    end else begin
                        state_q <= B_WAIT_RD;
                    end
                end
                B_WAIT_RD: begin
                    if (take_rd) begin
                        state_q  <= B_ACK;
                        wb_ack_o <= 1'b1;
                    end else if (!wb_stb_i) begin
                        // Master gave up, so drop the pending read.
                        state_q <= B_IDLE;
                    end
                end
                B_ACK: begin
                    state_q  <= B_IDLE;
                    wb_ack_o <= 1'b0;
                end
                default: begin
                    state_q <= B_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            dev_addr_o  <= wb_adr_i;
            dev_wdata_o <= wb_dat_i;
            dev_be_o    <= wb_sel_i;
        end
        if (take_rd) begin
            wb_dat_o <= dev_rdata_i;
        end
    end

endmodule

`default_nettype wire

// ==== wb_intercon.sv ====
// Wishbone interconnect: address decode, per device strobes, return mux and unmapped error.
`default_nettype none

module wb_intercon
    import bus_pkg::*;
#(
    parameter int unsigned NUM_DEV = 4
) (
    input  wire                             clk_i,
    input  wire                             rst_n_i,

    // Master side.
    input  wire                             wb_cyc_i,
    input  wire                             wb_stb_i,
    input  wire  [ADDR_W-1:0]               wb_adr_i,
    output logic [DATA_W-1:0]               wb_dat_o,
    output logic                            wb_ack_o,
    output logic                            wb_err_o,

    // Device side.
    output logic [NUM_DEV-1:0]              slv_stb_o,
    input  wire  [NUM_DEV-1:0]              slv_ack_i,
    input  wire  [NUM_DEV-1:0][DATA_W-1:0]  slv_dat_i
);

    localparam int unsigned IDX_W = $clog2(NUM_DEV);

    logic [IDX_W-1:0]   dev_idx;
    logic [IDX_W-1:0]   idx_q;
    logic               active_q;
    logic               req;
    logic               miss;

    assign req     = wb_cyc_i && wb_stb_i;
    assign dev_idx = wb_adr_i[DEV_SEL_LSB +: IDX_W];

    // Any bit above the index field points outside the map.
    assign miss = |wb_adr_i[ADDR_W-1:DEV_SEL_LSB+IDX_W];

    always_comb begin
        for (int k = 0; k < NUM_DEV; k++) begin
            slv_stb_o[k] = req && !miss && (dev_idx == IDX_W'(k));
        end
    end

    // Index is held from the first cycle so the return mux stays steady.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            active_q <= 1'b0;
            idx_q    <= '0;
        end else begin
            active_q <= wb_cyc_i;
            if (req && !active_q) begin
                idx_q <= dev_idx;
            end
        end
    end

    assign wb_ack_o = wb_cyc_i && active_q && slv_ack_i[idx_q];
    assign wb_dat_o = slv_dat_i[idx_q];
    assign wb_err_o = req && miss;

endmodule

`default_nettype wire

// ==== cmd_wb_master.sv ====
// Command port master that runs one Wishbone classic cycle per command, with a bus timeout.
`default_nettype none

module cmd_wb_master
    import bus_pkg::*;
#(
    parameter int unsigned TIMEOUT_CYC = 32
) (
    input  wire                 clk_i,
    input  wire                 rst_n_i,

    // Processor side.
    input  wire                 cmd_valid_i,
    input  wire                 cmd_we_i,
    input  wire  [ADDR_W-1:0]   cmd_addr_i,
    input  wire  [DATA_W-1:0]   cmd_wdata_i,
    input  wire  [BE_W-1:0]     cmd_be_i,
    output logic                cmd_busy_o,
    output logic                cmd_done_o,
    output logic                cmd_err_o,
    output logic [DATA_W-1:0]   cmd_rdata_o,

    // Wishbone side.
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output logic                wb_we_o,
    output logic [ADDR_W-1:0]   wb_adr_o,
    output logic [DATA_W-1:0]   wb_dat_o,
    output logic [BE_W-1:0]     wb_sel_o,
    input  wire  [DATA_W-1:0]   wb_dat_i,
    input  wire                 wb_ack_i,
    input  wire                 wb_err_i
);

    localparam int unsigned TMR_W = $clog2(TIMEOUT_CYC + 1);

    master_state_e      state_q;
    logic [TMR_W-1:0]   timer_q;
    logic               accept;
    logic               finish;
    logic               timeout;

    assign accept  = (state_q == M_IDLE) && cmd_valid_i;
    assign finish  = wb_ack_i || wb_err_i || (timer_q == '0);
    assign timeout = (timer_q == '0) && !wb_ack_i && !wb_err_i;

    // Busy covers the whole bus cycle and the completion cycle.
    assign cmd_busy_o = (state_q != M_IDLE);

    // ##############################
    // Cycle control.
    // ##############################

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= M_IDLE;
            timer_q    <= '0;
            wb_cyc_o   <= 1'b0;
            wb_stb_o   <= 1'b0;
            cmd_done_o <= 1'b0;
            cmd_err_o  <= 1'b0;
        end else begin
            case (state_q)
                M_IDLE: begin
                    if (cmd_valid_i) begin
                        state_q  <= M_CYCLE;
                        timer_q  <= TMR_W'(TIMEOUT_CYC);
                        wb_cyc_o <= 1'b1;
                        wb_stb_o <= 1'b1;
                    end
                end
                M_CYCLE: begin
                    if (finish) begin
                        // Drop the cycle on the same edge that sees ack or err.
                        state_q    <= M_DONE;
                        wb_cyc_o   <= 1'b0;
                        wb_stb_o   <= 1'b0;
                        cmd_done_o <= 1'b1;
                        cmd_err_o  <= wb_err_i || timeout;
                    end else begin
                        timer_q <= timer_q - 1'b1;
                    end
                end
                M_DONE: begin
                    state_q    <= M_IDLE;
                    cmd_done_o <= 1'b0;
                    cmd_err_o  <= 1'b0;
                end
                default: begin
                    state_q <= M_IDLE;
                end
            endcase
        end
    end

    // ##############################
    // Bus payload and read return.
    // ##############################

    always_ff @(posedge clk_i) begin
        if (accept) begin
            wb_we_o  <= cmd_we_i;
            wb_adr_o <= cmd_addr_i;
            wb_dat_o <= cmd_wdata_i;
            wb_sel_o <= cmd_be_i;
        end
        if ((state_q == M_CYCLE) && finish) begin
            // Zero on error, timeout or write.
            cmd_rdata_o <= (wb_ack_i && !wb_err_i && !wb_we_o) ? wb_dat_i : '0;
        end
    end

endmodule

`default_nettype wire

// ==== bus_pkg.sv ====
// Shared bus widths, address map constants and FSM state types.
`default_nettype none

package bus_pkg;

    // ##############################
    // Bus widths.
    // ##############################

    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned BE_W   = DATA_W / 8;

    // ##############################
    // Address map.
    // ##############################

    // Device index starts here, each device owns a 4 KiB window.
    localparam int unsigned DEV_SEL_LSB = 12;
    localparam int unsigned LOC_W       = DEV_SEL_LSB;

    typedef enum logic [1:0] {
        M_IDLE,
        M_CYCLE,
        M_DONE
    } master_state_e;

    typedef enum logic [2:0] {
        B_IDLE,
        B_WAIT_RDY,
        B_ACCESS,
        B_WAIT_RD,
        B_ACK
    } bridge_state_e;

endpackage

`default_nettype wire
